/* filelist.f */
verilog/rgmii_line_pkg.sv
verilog/tx_stage_pkg.sv
verilog/synchronous_fifo.sv
verilog/ddr_output_buffer.sv
verilog/stage_idle_timer.sv
verilog/rgmii_byte_shipper.sv
sim/tb_clock_gen.sv
sim/rgmii_byte_shipper_sva.sv
sim/rgmii_byte_shipper_tb.sv

/* sim/rgmii_byte_shipper_sva.sv */
`timescale 1ns/1ns

module rgmii_byte_shipper_sva (
    input logic                         clock,
    input logic                         reset_n,
    input logic                         data_enable,
    input logic                         data_ready,
    input logic                         fifo_write_enable,
    input logic                         fifo_full,
    input tx_stage_pkg::shipper_state_t state,
    input logic                         frame_data_valid,
    input logic                         shipped_data_valid
);

    assert property (@(posedge clock) disable iff (!reset_n)
        !(fifo_write_enable && fifo_full))
        else $error("stage FIFO written while full");

    assert property (@(posedge clock) disable iff (!reset_n)
        data_ready |-> data_enable)
        else $error("data_ready high without data_enable");

    assert property (@(posedge clock) disable iff (!reset_n)
        (state == tx_stage_pkg::gap) |-> !frame_data_valid)
        else $error("frame byte marked valid in gap");

    // Reset edge clears both DDR halves
    assert property (@(posedge clock) !reset_n |=> !shipped_data_valid)
        else $error("shipped_data_valid high after reset");

endmodule

bind rgmii_byte_shipper rgmii_byte_shipper_sva shipper_sva (
    .clock              (clock),
    .reset_n            (reset_n),
    .data_enable        (data_enable),
    .data_ready         (data_ready),
    .fifo_write_enable  (stage_data_valid),
    .fifo_full          (stage_fifo_full),
    .state              (state),
    .frame_data_valid   (frame_data_valid),
    .shipped_data_valid (shipped_data_valid)
);

/* sim/rgmii_byte_shipper_tb.sv */
`timescale 1ns/1ns

module rgmii_byte_shipper_tb;

    localparam int FRAME_COUNT  = 12;
    localparam int WAIT_LIMIT   = 200;
    localparam int DRAIN_LIMIT  = 1000;
    localparam int GAP_MINIMUM  = rgmii_line_pkg::INTER_PACKET_GAP_CYCLES + 1;
    localparam int STALL_LIMIT  = int'(tx_stage_pkg::IDLE_TIMEOUT_LIMIT);
    localparam int PREAMBLE_LEN = 7;
    localparam int HEADER_BYTES = PREAMBLE_LEN + 1;

    logic                       clock;
    logic                       reset_n;
    tx_stage_pkg::staged_word_t data;
    logic                       data_enable;
    logic                       data_ready;
    rgmii_line_pkg::nibble_t    shipped_data;
    logic                       shipped_data_valid;

    logic [15:0] lfsr_state = 16'd87;
    int          error_count;
    int          frames_checked;
    int          open_length;
    bit          valid_seen;
    bit          in_frame;
    logic [7:0]  expected_bytes[$];
    int          frame_lengths[$];
    logic [7:0]  received[$];

    tb_clock_gen clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    rgmii_byte_shipper UUT (
        .clock              (clock),
        .reset_n            (reset_n),
        .data               (data),
        .data_enable        (data_enable),
        .data_ready         (data_ready),
        .shipped_data       (shipped_data),
        .shipped_data_valid (shipped_data_valid)
    );

    ////////////////////
    // Helpers

    // Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 16'hb400;
        end
        return value >> 1;
    endfunction

    function automatic int draw_bits(input int count);
        int result;
        result = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            result = (result << 1) | lfsr_state[0];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("Checked %0d frames, %0d errors", frames_checked, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic timeout_failure(input string what);
        $display("Timed out waiting for %0s", what);
        error_count++;
        finish_run();
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic idle(input int cycles);
        data_enable = 1'b0;
        repeat (cycles) begin
            next_cycle();
        end
    endtask

    // Holds the word until taken, counts the refused cycles
    task automatic send_word(input tx_stage_pkg::staged_word_t word, output int refused);
        bit accepted;
        accepted    = 1'b0;
        refused     = 0;
        data        = word;
        data_enable = 1'b1;
        while (!accepted && refused < WAIT_LIMIT) begin
            #80;
            accepted = data_ready;
            if (!accepted) begin
                refused++;
            end
            next_cycle();
        end
        data_enable = 1'b0;
        if (!accepted) begin
            timeout_failure("data_ready");
        end
    endtask

    task automatic close_frame();
        if (open_length > 0) begin
            frame_lengths.push_back(open_length);
        end
        open_length = 0;
    endtask

    task automatic check_frame();
        int         expected_length;
        int         errors_before;
        logic [7:0] expected;
        errors_before = error_count;
        if (frame_lengths.size() == 0) begin
            $display("A frame of %0d bytes was sent with none expected", received.size());
            error_count++;
        end
        else begin
            expected_length = frame_lengths.pop_front();
            check_value("frame byte count", received.size(), expected_length + HEADER_BYTES);
            for (int i = 0; i < expected_length + HEADER_BYTES; i++) begin
                if (i < PREAMBLE_LEN) begin
                    expected = 8'h55;
                end
                else if (i == PREAMBLE_LEN) begin
                    expected = 8'hd5;
                end
                else begin
                    expected = expected_bytes.pop_front();
                end
                if (i < received.size()) begin
                    check_value("shipped_data", received[i], expected);
                end
            end
        end
        frames_checked++;
        $display("frame %0d: %0d bytes, %0s", frames_checked, received.size(),
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    ////////////////////
    // Output monitor

    initial begin
        logic       valid_low;
        logic       valid_high;
        logic [3:0] low_nibble;
        int         gap_cycles;
        bit         first_frame;
        in_frame    = 1'b0;
        valid_seen  = 1'b0;
        gap_cycles  = 0;
        first_frame = 1'b1;
        forever begin
            @(posedge clock);
            #25;
            low_nibble = shipped_data;
            valid_low  = shipped_data_valid;
            #50;
            valid_high = shipped_data_valid;
            if (reset_n) begin
                check_value("shipped_data_valid upper half", valid_high, valid_low);
            end
            if (valid_low === 1'b1) begin
                valid_seen = 1'b1;
                if (!in_frame) begin
                    if (!first_frame) begin
                        check_value("valid low gap long enough", gap_cycles >= GAP_MINIMUM, 1);
                    end
                    first_frame = 1'b0;
                    in_frame    = 1'b1;
                    gap_cycles  = 0;
                    received.delete();
                end
                received.push_back({shipped_data, low_nibble});
            end
            else begin
                if (in_frame) begin
                    check_frame();
                end
                in_frame = 1'b0;
                gap_cycles++;
            end
        end
    end

    ////////////////////
    // Stimulus

    initial begin
        int                         length;
        int                         stall;
        int                         refused;
        int                         errors_before;
        int                         drain_cycles;
        int                         reset_cycles;
        bit                         split;
        bit                         had_open;
        bit                         end_by_timeout;
        tx_stage_pkg::staged_word_t word;

        error_count    = 0;
        frames_checked = 0;
        open_length    = 0;
        data           = '0;
        data_enable    = 1'b0;

        reset_cycles = 0;
        while (reset_n !== 1'b1 && reset_cycles < WAIT_LIMIT) begin
            @(posedge clock);
            reset_cycles++;
        end
        if (reset_n !== 1'b1) begin
            timeout_failure("reset release");
        end
        #10;

        // Unmarked words in find_start are taken and dropped
        errors_before = error_count;
        repeat (3) begin
            send_word({1'b0, 8'(draw_bits(8))}, refused);
        end
        idle(20);
        check_value("shipped_data_valid seen", valid_seen, 1'b0);
        $display("idle after reset: %0s", (error_count == errors_before) ? "ok" : "mismatch");

        for (int f = 0; f < FRAME_COUNT; f++) begin
            length         = draw_bits(6) % 40 + 1;
            end_by_timeout = draw_bits(1);
            split          = 1'b1;
            for (int i = 0; i < length; i++) begin
                word     = {split, 8'(draw_bits(8))};
                had_open = (open_length > 0);
                if (split) begin
                    close_frame();
                end
                send_word(word, refused);
                if (split && had_open) begin
                    check_value("data_ready low through gap", refused >= GAP_MINIMUM, 1);
                end
                expected_bytes.push_back(word[7:0]);
                open_length++;
                stall = (draw_bits(2) == 0) ? draw_bits(3) % 7 : 0;
                idle(stall);
                // A stall past the idle limit closes the frame here
                split = (stall > STALL_LIMIT);
            end
            if (end_by_timeout) begin
                close_frame();
                idle(STALL_LIMIT + 2);
                if (draw_bits(1)) begin
                    send_word({1'b0, 8'(draw_bits(8))}, refused);
                end
            end
        end
        close_frame();
        idle(STALL_LIMIT + 2);

        drain_cycles = 0;
        while ((frame_lengths.size() > 0 || in_frame) && drain_cycles < DRAIN_LIMIT) begin
            next_cycle();
            drain_cycles++;
        end
        if (frame_lengths.size() > 0 || in_frame) begin
            timeout_failure("the last frames on the output");
        end
        else begin
            finish_run();
        end
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        clock = 1'b0;
        forever begin
            #HALF_PERIOD clock = ~clock;
        end
    end

    // Released just after a rising edge, like the other inputs
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clock);
        end
        #10 reset_n = 1'b1;
    end

endmodule

/* verilog/ddr_output_buffer.sv */
`timescale 1ns/1ns

module ddr_output_buffer #(
    parameter int OUTPUT_WIDTH = 4
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic [2*OUTPUT_WIDTH-1:0] ddr_input,
    output logic [OUTPUT_WIDTH-1:0]   ddr_output
);

    logic [2*OUTPUT_WIDTH-1:0] registered_input;
    logic [OUTPUT_WIDTH-1:0]   lower_half;
    logic [OUTPUT_WIDTH-1:0]   upper_half;

    ////////////////////
    // Capture

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            registered_input <= '0;
        end
        else begin
            registered_input <= ddr_input;
        end
    end

    assign lower_half = registered_input[OUTPUT_WIDTH-1:0];
    assign upper_half = registered_input[2*OUTPUT_WIDTH-1:OUTPUT_WIDTH];

    ////////////////////
    // Phase select

    // Lower half in the high phase, upper half in the low phase
    assign ddr_output = clock ? lower_half : upper_half;

endmodule

/* verilog/rgmii_byte_shipper.sv */
`timescale 1ns/1ns

module rgmii_byte_shipper (
    input  logic                       clock,
    input  logic                       reset_n,
    input  tx_stage_pkg::staged_word_t data,
    input  logic                       data_enable,
    output logic                       data_ready,
    output rgmii_line_pkg::nibble_t    shipped_data,
    output logic                       shipped_data_valid
);

    // Wide enough for a full FIFO of staged bytes and for preamble and gap
    typedef logic [$clog2(tx_stage_pkg::STAGE_FIFO_DEPTH + 1)-1:0] shipper_count_t;

    logic                  stage_fifo_reset_n;
    logic                  stage_fifo_read_enable;
    rgmii_line_pkg::byte_t stage_fifo_read_data;
    logic                  stage_fifo_read_data_valid;
    logic                  stage_fifo_full;

    logic timer_load_count;
    logic timer_expired;
    logic frame_full;
    logic start_marker;

    tx_stage_pkg::shipper_state_t state;
    tx_stage_pkg::shipper_state_t next_state;
    shipper_count_t               counter;
    shipper_count_t               next_counter;
    rgmii_line_pkg::byte_t        stage_data;
    rgmii_line_pkg::byte_t        next_stage_data;
    logic                         stage_data_valid;
    logic                         next_stage_data_valid;
    rgmii_line_pkg::byte_t        frame_data;
    rgmii_line_pkg::byte_t        next_frame_data;
    logic                         frame_data_valid;
    logic                         next_frame_data_valid;
    logic                         stage_fifo_flush;
    logic                         next_stage_fifo_flush;

    ////////////////////
    // Submodules

    synchronous_fifo #(
        .DATA_WIDTH ($bits(rgmii_line_pkg::byte_t)),
        .DATA_DEPTH (tx_stage_pkg::STAGE_FIFO_DEPTH)
    ) stage_fifo (
        .clock           (clock),
        .reset_n         (stage_fifo_reset_n),
        .read_enable     (stage_fifo_read_enable),
        .write_enable    (stage_data_valid),
        .write_data      (stage_data),
        .read_data       (stage_fifo_read_data),
        .read_data_valid (stage_fifo_read_data_valid),
        .full            (stage_fifo_full),
        .empty           ()
    );

    ddr_output_buffer #(
        .OUTPUT_WIDTH ($bits(rgmii_line_pkg::nibble_t))
    ) data_ddr_output_buffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .ddr_input  (frame_data),
        .ddr_output (shipped_data)
    );

    ddr_output_buffer #(
        .OUTPUT_WIDTH (1)
    ) data_valid_ddr_output_buffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .ddr_input  ({2{frame_data_valid}}),
        .ddr_output (shipped_data_valid)
    );

    stage_idle_timer timeout_timer (
        .clock      (clock),
        .reset_n    (reset_n),
        .load_count (timer_load_count),
        .expired    (timer_expired)
    );

    // Flush empties the FIFO once a frame has been sent
    assign stage_fifo_reset_n = reset_n && !stage_fifo_flush;

    assign start_marker = data[8];
    assign frame_full   = stage_fifo_full ||
                          (counter == shipper_count_t'(tx_stage_pkg::STAGE_FIFO_DEPTH));

    ////////////////////
    // Framer FSM

    always_comb begin
        next_state             = state;
        next_counter           = counter;
        next_stage_data        = stage_data;
        next_stage_data_valid  = 1'b0;
        next_frame_data        = frame_data;
        next_frame_data_valid  = 1'b0;
        next_stage_fifo_flush  = 1'b0;
        data_ready             = 1'b0;
        timer_load_count       = 1'b0;
        stage_fifo_read_enable = 1'b0;

        case (state)
            tx_stage_pkg::find_start: begin
                timer_load_count = 1'b1;
                // Unmarked words are taken and dropped here
                if (data_enable) begin
                    data_ready = 1'b1;
                    if (start_marker) begin
                        next_stage_data       = data[7:0];
                        next_stage_data_valid = 1'b1;
                        next_counter          = shipper_count_t'(1);
                        next_state            = tx_stage_pkg::stage;
                    end
                end
            end
            tx_stage_pkg::stage: begin
                if (data_enable && !start_marker && !frame_full) begin
                    data_ready            = 1'b1;
                    next_stage_data       = data[7:0];
                    next_stage_data_valid = 1'b1;
                    next_counter          = counter + 1'b1;
                    timer_load_count      = 1'b1;
                end
                else if ((data_enable && start_marker) || frame_full || timer_expired) begin
                    // Next start word is held by the source until after the gap
                    next_counter = shipper_count_t'(rgmii_line_pkg::PREAMBLE_LENGTH - 1);
                    next_state   = tx_stage_pkg::preamble;
                end
            end
            tx_stage_pkg::preamble: begin
                next_frame_data       = rgmii_line_pkg::PREAMBLE_BYTE;
                next_frame_data_valid = 1'b1;
                next_counter          = counter - 1'b1;
                if (counter == '0) begin
                    next_state = tx_stage_pkg::start_of_frame;
                end
            end
            tx_stage_pkg::start_of_frame: begin
                next_frame_data       = rgmii_line_pkg::SFD_BYTE;
                next_frame_data_valid = 1'b1;
                next_counter          = shipper_count_t'(rgmii_line_pkg::INTER_PACKET_GAP_CYCLES);
                next_state            = tx_stage_pkg::frame;
            end
            tx_stage_pkg::frame: begin
                if (stage_fifo_read_data_valid) begin
                    next_frame_data        = stage_fifo_read_data;
                    next_frame_data_valid  = 1'b1;
                    stage_fifo_read_enable = 1'b1;
                end
                else begin
                    next_stage_fifo_flush = 1'b1;
                    next_state            = tx_stage_pkg::gap;
                end
            end
            tx_stage_pkg::gap: begin
                next_counter = counter - 1'b1;
                if (counter == '0) begin
                    next_state = tx_stage_pkg::find_start;
                end
            end
            default: begin
                next_state = tx_stage_pkg::find_start;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state            <= tx_stage_pkg::find_start;
            counter          <= '0;
            stage_data_valid <= 1'b0;
            frame_data       <= '0;
            frame_data_valid <= 1'b0;
            stage_fifo_flush <= 1'b0;
        end
        else begin
            state            <= next_state;
            counter          <= next_counter;
            stage_data_valid <= next_stage_data_valid;
            frame_data       <= next_frame_data;
            frame_data_valid <= next_frame_data_valid;
            stage_fifo_flush <= next_stage_fifo_flush;
        end
    end

    always_ff @(posedge clock) begin
        stage_data <= next_stage_data;
    end

endmodule

/* verilog/rgmii_line_pkg.sv */
package rgmii_line_pkg;

    ////////////////////
    // Wire side types

    // One DDR half of a line byte
    typedef logic [3:0] nibble_t;

    typedef logic [7:0] byte_t;

    ////////////////////
    // Ethernet framing

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;

    localparam int PREAMBLE_LENGTH = 7;

    // 96 ns at 125 MHz
    localparam int INTER_PACKET_GAP_CYCLES = 12;

endpackage

/* verilog/stage_idle_timer.sv */
`timescale 1ns/1ns

module stage_idle_timer (
    input  logic clock,
    input  logic reset_n,
    input  logic load_count,
    output logic expired
);

    tx_stage_pkg::timer_count_t count;

    // Starts full so expired stays low out of reset
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= tx_stage_pkg::IDLE_TIMEOUT_LIMIT;
        end
        else if (load_count) begin
            count <= tx_stage_pkg::IDLE_TIMEOUT_LIMIT;
        end
        else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Holds at zero until the next load
    assign expired = (count == '0);

endmodule

/* verilog/synchronous_fifo.sv */
`timescale 1ns/1ns

module synchronous_fifo #(
    parameter int DATA_WIDTH = $bits(rgmii_line_pkg::byte_t),
    parameter int DATA_DEPTH = tx_stage_pkg::STAGE_FIFO_DEPTH
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  logic [DATA_WIDTH-1:0] write_data,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_data_valid,
    output logic                  full,
    output logic                  empty
);

    typedef logic [$clog2(DATA_DEPTH)-1:0]   address_t;
    typedef logic [$clog2(DATA_DEPTH+1)-1:0] count_t;

    logic [DATA_WIDTH-1:0] memory [DATA_DEPTH];

    address_t write_pointer;
    address_t read_pointer;
    count_t   occupancy;
    logic     write_accept;
    logic     read_accept;

    // Pointers wrap at the last entry, depth need not be a power of two
    function automatic address_t next_address(input address_t address);
        if (address == address_t'(DATA_DEPTH - 1)) begin
            return '0;
        end
        return address + 1'b1;
    endfunction

    assign full  = (occupancy == count_t'(DATA_DEPTH));
    assign empty = (occupancy == '0);

    // Overflow and underflow requests are dropped
    assign write_accept = write_enable && !full;
    assign read_accept  = read_enable && !empty;

    // Head entry shown without a read request
    assign read_data       = memory[read_pointer];
    assign read_data_valid = !empty;

    always_ff @(posedge clock) begin
        if (write_accept) begin
            memory[write_pointer] <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            occupancy     <= '0;
        end
        else begin
            if (write_accept) begin
                write_pointer <= next_address(write_pointer);
            end

            if (read_accept) begin
                read_pointer <= next_address(read_pointer);
            end

            case ({write_accept, read_accept})
                2'b10: begin
                    occupancy <= occupancy + 1'b1;
                end
                2'b01: begin
                    occupancy <= occupancy - 1'b1;
                end
                default: begin
                    occupancy <= occupancy;
                end
            endcase
        end
    end

endmodule

/* verilog/tx_stage_pkg.sv */
package tx_stage_pkg;

    ////////////////////
    // Staging types

    // Bit 8 marks the first byte of a frame, bits 7..0 carry the byte
    typedef logic [8:0] staged_word_t;

    typedef logic [15:0] timer_count_t;

    ////////////////////
    // Staging limits

    // Idle cycles before a staged frame is closed
    localparam timer_count_t IDLE_TIMEOUT_LIMIT = 16'd4;

    localparam int STAGE_FIFO_DEPTH = 2048;

    // Framer states
    typedef enum logic [2:0] {
        find_start,
        stage,
        preamble,
        start_of_frame,
        frame,
        gap
    } shipper_state_t;

endpackage
